//--- Makefile
.PHONY: help test clean

help:
	@echo "make test   build rv_core_tb with Verilator and run it"
	@echo "make clean  remove the Verilator build directory"
	@echo "make help   show this list"

test:
	verilator --binary --timing --assert -j 0 --top-module rv_core_tb \
		-f list.f -Mdir obj_dir
	./obj_dir/Vrv_core_tb

clean:
	rm -rf obj_dir

//--- hw/rv_alu.sv
`timescale 1ns/1ps
`include "rv_consts.svh"

module rv_alu import rv_pkg::*; (
    input  word_t   a,
    input  word_t   b,
    input  alu_op_t op,
    output word_t   y,
    output logic    zero                // y == 0, branch compare
);

    word_t sum;
    word_t diff;
    logic  lt;                          // signed a < b

    assign sum  = a + b;
    assign diff = a - b;
    assign lt   = $signed(a) < $signed(b);

    always_comb begin
        case (op)
            `ALU_ADD: y = sum;
            `ALU_SUB: y = diff;
            `ALU_SLT: y = {{(`XLEN-1){1'b0}}, lt};
            `ALU_AND: y = a & b;
            `ALU_OR:  y = a | b;
            `ALU_XOR: y = a ^ b;
            default:  y = sum;          // unused codes behave as add
        endcase
    end

    assign zero = (y == '0);

endmodule

//--- hw/rv_consts.svh
`ifndef RV_CONSTS_SVH
`define RV_CONSTS_SVH

`define XLEN        32
`define RESET_PC    32'h0000_0000       // first fetch after reset

// major opcodes, inst[6:0]
`define OP_LUI      7'b0110111
`define OP_AUIPC    7'b0010111
`define OP_JAL      7'b1101111
`define OP_BRANCH   7'b1100011
`define OP_LOAD     7'b0000011
`define OP_STORE    7'b0100011
`define OP_IMM      7'b0010011
`define OP_REG      7'b0110011

`define ALU_ADD     4'd0
`define ALU_SUB     4'd1
`define ALU_SLT     4'd2                // signed compare
`define ALU_AND     4'd3
`define ALU_OR      4'd4
`define ALU_XOR     4'd5

`define IMM_I       3'd0
`define IMM_S       3'd1
`define IMM_B       3'd2
`define IMM_U       3'd3
`define IMM_J       3'd4

`define RES_ALU     2'd0
`define RES_MEM     2'd1
`define RES_PC4     2'd2                // link value for jal

`define SIZE_B      2'd0                // bus size codes, also funct3[1:0]
`define SIZE_H      2'd1
`define SIZE_W      2'd2

`endif

//--- hw/rv_core_top.sv
`timescale 1ns/1ps
`include "rv_consts.svh"

module rv_core_top import rv_pkg::*; (
    input  logic  clk,
    input  logic  arst_n,
    input  word_t idt,                  // instruction word at iad
    output addr_t iad,                  // instruction address
    output addr_t dad,                  // data address
    output logic  mreq,                 // data bus request
    output logic  write,                // store when high
    output size_t size,
    inout  wire [`XLEN-1:0] ddt         // shared data bus
);

    ctrl_t ctrl;
    logic  zero;
    word_t store_data;
    word_t load_data;
    logic  drive_ddt;                   // core owns ddt on stores

    rv_decoder u_decoder (
        .arst_n (arst_n),
        .inst   (idt),
        .zero   (zero),
        .ctrl   (ctrl)
    );

    rv_datapath u_datapath (
        .clk        (clk),
        .arst_n     (arst_n),
        .inst       (idt),
        .ctrl       (ctrl),
        .load_data  (load_data),
        .zero       (zero),
        .pc         (iad),
        .alu_result (dad),
        .store_data (store_data)
    );

    assign mreq  = ctrl.mem_req;
    assign write = ctrl.mem_write;
    assign size  = ctrl.size;

    // release ddt for loads so memory can drive it
    assign drive_ddt = ctrl.mem_req && ctrl.mem_write;
    assign ddt       = drive_ddt ? store_data : 'z;
    assign load_data = ddt;

endmodule

//--- hw/rv_datapath.sv
`timescale 1ns/1ps
`include "rv_consts.svh"

module rv_datapath import rv_pkg::*; (
    input  logic  clk,
    input  logic  arst_n,
    input  word_t inst,
    input  ctrl_t ctrl,
    input  word_t load_data,            // right-justified from memory
    output logic  zero,
    output addr_t pc,
    output word_t alu_result,           // also data address
    output word_t store_data
);

    reg_idx_t rs1;
    reg_idx_t rs2;
    reg_idx_t rd;
    word_t    imm;
    word_t    rd1;
    word_t    rd2;
    word_t    op_a;
    word_t    op_b;
    word_t    load_ext;                 // sign-extended load item
    word_t    wb_data;
    addr_t    pc_plus4;
    addr_t    pc_target;
    addr_t    pc_next;

    assign rs1 = inst[19:15];
    assign rs2 = inst[24:20];
    assign rd  = inst[11:7];

    // immediate by instruction format
    always_comb begin
        case (ctrl.imm_sel)
            `IMM_I:  imm = {{20{inst[31]}}, inst[31:20]};
            `IMM_S:  imm = {{20{inst[31]}}, inst[31:25], inst[11:7]};
            `IMM_B:  imm = {{19{inst[31]}}, inst[31], inst[7], inst[30:25],
                            inst[11:8], 1'b0};
            `IMM_U:  imm = {inst[31:12], 12'b0};
            `IMM_J:  imm = {{11{inst[31]}}, inst[31], inst[19:12], inst[20],
                            inst[30:21], 1'b0};
            default: imm = '0;
        endcase
    end

    rv_regfile u_regfile (
        .clk    (clk),
        .arst_n (arst_n),
        .rs1    (rs1),
        .rs2    (rs2),
        .rd     (rd),
        .we     (ctrl.reg_write),
        .wd     (wb_data),
        .rd1    (rd1),
        .rd2    (rd2)
    );

    // operand a: rs1, pc for auipc, zero for lui
    assign op_a = ctrl.a_zero   ? '0 :
                  ctrl.a_src_pc ? pc : rd1;
    assign op_b = ctrl.alu_src_imm ? imm : rd2;

    rv_alu u_alu (
        .a    (op_a),
        .b    (op_b),
        .op   (ctrl.alu_op),
        .y    (alu_result),
        .zero (zero)
    );

    always_comb begin
        case (ctrl.size)
            `SIZE_B: load_ext = {{24{load_data[7]}}, load_data[7:0]};
            `SIZE_H: load_ext = {{16{load_data[15]}}, load_data[15:0]};
            default: load_ext = load_data;      // word
        endcase
    end

    assign pc_plus4  = pc + 32'd4;
    assign pc_target = pc + imm;        // jal and branches

    always_comb begin
        case (ctrl.res_sel)
            `RES_MEM: wb_data = load_ext;
            `RES_PC4: wb_data = pc_plus4;
            default:  wb_data = alu_result;
        endcase
    end

    assign pc_next    = ctrl.pc_jump ? pc_target : pc_plus4;
    assign store_data = rd2;            // memory takes the low size bytes

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            pc <= `RESET_PC;
        end else begin
            pc <= pc_next;              // one instruction per clock
        end
    end

endmodule

//--- hw/rv_decoder.sv
`timescale 1ns/1ps
`include "rv_consts.svh"

module rv_decoder import rv_pkg::*; (
    input  logic  arst_n,
    input  word_t inst,                 // current instruction word
    input  logic  zero,                 // from ALU, rs1 - rs2 == 0
    output ctrl_t ctrl
);

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic       funct7_b5;              // sub vs add
    logic       known;                  // opcode and funct3 supported

    assign opcode    = inst[6:0];
    assign funct3    = inst[14:12];
    assign funct7_b5 = inst[30];

    always_comb begin
        ctrl        = '0;               // nop unless decoded below
        ctrl.alu_op = `ALU_ADD;
        known       = 1'b1;
        case (opcode)
            `OP_LUI: begin
                ctrl.a_zero      = 1'b1;   // 0 + imm
                ctrl.alu_src_imm = 1'b1;
                ctrl.imm_sel     = `IMM_U;
                ctrl.reg_write   = 1'b1;
            end
            `OP_AUIPC: begin
                ctrl.a_src_pc    = 1'b1;   // pc + imm
                ctrl.alu_src_imm = 1'b1;
                ctrl.imm_sel     = `IMM_U;
                ctrl.reg_write   = 1'b1;
            end
            `OP_JAL: begin
                ctrl.imm_sel   = `IMM_J;
                ctrl.res_sel   = `RES_PC4; // rd = pc + 4
                ctrl.reg_write = 1'b1;
                ctrl.pc_jump   = 1'b1;
            end
            `OP_BRANCH: begin
                ctrl.alu_op  = `ALU_SUB;   // compare through zero flag
                ctrl.imm_sel = `IMM_B;
                case (funct3)
                    3'b000:  ctrl.pc_jump = zero;   // beq
                    3'b001:  ctrl.pc_jump = !zero;  // bne
                    default: known = 1'b0;
                endcase
            end
            `OP_LOAD: begin
                ctrl.alu_src_imm = 1'b1;   // rs1 + offset
                ctrl.imm_sel     = `IMM_I;
                ctrl.res_sel     = `RES_MEM;
                ctrl.reg_write   = 1'b1;
                ctrl.mem_req     = 1'b1;
                ctrl.size        = funct3[1:0];
                if (funct3[2] || funct3[1:0] == 2'b11) known = 1'b0; // no lbu/lhu
            end
            `OP_STORE: begin
                ctrl.alu_src_imm = 1'b1;
                ctrl.imm_sel     = `IMM_S;
                ctrl.mem_req     = 1'b1;
                ctrl.mem_write   = 1'b1;
                ctrl.size        = funct3[1:0];
                if (funct3[2] || funct3[1:0] == 2'b11) known = 1'b0;
            end
            `OP_IMM: begin
                ctrl.alu_src_imm = 1'b1;
                ctrl.imm_sel     = `IMM_I;
                ctrl.reg_write   = 1'b1;
                case (funct3)
                    3'b000:  ctrl.alu_op = `ALU_ADD;
                    3'b010:  ctrl.alu_op = `ALU_SLT;
                    3'b100:  ctrl.alu_op = `ALU_XOR;
                    3'b110:  ctrl.alu_op = `ALU_OR;
                    3'b111:  ctrl.alu_op = `ALU_AND;
                    default: known = 1'b0;  // shifts, sltiu
                endcase
            end
            `OP_REG: begin
                ctrl.reg_write = 1'b1;
                case (funct3)
                    3'b000:  ctrl.alu_op = funct7_b5 ? `ALU_SUB : `ALU_ADD;
                    3'b010:  ctrl.alu_op = `ALU_SLT;
                    3'b100:  ctrl.alu_op = `ALU_XOR;
                    3'b110:  ctrl.alu_op = `ALU_OR;
                    3'b111:  ctrl.alu_op = `ALU_AND;
                    default: known = 1'b0;
                endcase
            end
            default: known = 1'b0;
        endcase

        // no side effects in reset or on unsupported encodings
        if (!arst_n || !known) begin
            ctrl.mem_req   = 1'b0;
            ctrl.mem_write = 1'b0;
            ctrl.reg_write = 1'b0;
            ctrl.pc_jump   = 1'b0;          // fall through to pc + 4
        end
    end

endmodule

//--- hw/rv_pkg.sv
`include "rv_consts.svh"

package rv_pkg;

    typedef logic [`XLEN-1:0] word_t;   // data value
    typedef logic [`XLEN-1:0] addr_t;   // byte address
    typedef logic [4:0]       reg_idx_t; // x0..x31

    typedef logic [3:0] alu_op_t;       // ALU_* codes
    typedef logic [2:0] imm_sel_t;      // IMM_* codes
    typedef logic [1:0] res_sel_t;      // RES_* codes
    typedef logic [1:0] size_t;         // SIZE_* codes

    // control bundle from decoder to datapath
    typedef struct packed {
        alu_op_t  alu_op;               // ALU operation
        logic     alu_src_imm;          // b = immediate
        logic     a_src_pc;             // a = pc, auipc
        logic     a_zero;               // a = 0, lui
        imm_sel_t imm_sel;              // immediate format
        res_sel_t res_sel;              // write-back source
        logic     reg_write;            // commit rd on the edge
        logic     pc_jump;              // next pc = pc + imm
        logic     mem_req;              // bus access this cycle
        logic     mem_write;            // store when set
        size_t    size;                 // access width
    } ctrl_t;

endpackage

//--- hw/rv_regfile.sv
`timescale 1ns/1ps

module rv_regfile import rv_pkg::*; (
    input  logic     clk,
    input  logic     arst_n,
    input  reg_idx_t rs1,
    input  reg_idx_t rs2,
    input  reg_idx_t rd,
    input  logic     we,
    input  word_t    wd,
    output word_t    rd1,
    output word_t    rd2
);

    word_t regs [31:1];                 // x0 has no storage

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (we && rd != 5'd0) begin // x0 writes dropped
            regs[rd] <= wd;
        end
    end

    // combinational read ports, x0 hardwired to zero
    always_comb begin
        rd1 = '0;
        rd2 = '0;
        if (rs1 != 5'd0) begin
            rd1 = regs[rs1];
        end
        if (rs2 != 5'd0) begin
            rd2 = regs[rs2];
        end
    end

endmodule

//--- list.f
+incdir+hw
hw/rv_pkg.sv
hw/rv_regfile.sv
hw/rv_alu.sv
hw/rv_decoder.sv
hw/rv_datapath.sv
hw/rv_core_top.sv
verification/rv_core_asserts.sv
verification/rv_core_tb.sv

//--- verification/rv_core_asserts.sv
`timescale 1ns/1ps

module rv_core_asserts import rv_pkg::*; (
    input logic  clk,
    input logic  arst_n,
    input addr_t iad,
    input logic  mreq,
    input logic  write,
    input word_t ddt
);

    // bus stays quiet while in reset
    a_quiet_in_reset: assert property (@(posedge clk) !arst_n |-> !mreq && !write)
        else $error("mreq or write high during reset");

    a_write_needs_req: assert property (@(posedge clk) write |-> mreq)
        else $error("write without mreq");

    // core must own ddt on a store
    a_store_drives_ddt: assert property (@(posedge clk) disable iff (!arst_n)
        (mreq && write) |-> !$isunknown(ddt))
        else $error("ddt floating during store");

    a_iad_aligned: assert property (@(posedge clk) iad[1:0] == 2'b00)
        else $error("iad not word aligned");

endmodule

bind rv_core_top rv_core_asserts i_asserts (
    .clk    (clk),
    .arst_n (arst_n),
    .iad    (iad),
    .mreq   (mreq),
    .write  (write),
    .ddt    (ddt)
);

//--- verification/rv_core_tb.sv
`timescale 1ns/1ps
`include "rv_consts.svh"

module rv_core_tb import rv_pkg::*; ();

    typedef struct packed {
        word_t inst;                        // instruction at iad
        addr_t iad;
        logic  mreq;
        logic  write;
        size_t size;
        addr_t dad;
        word_t wdata;                       // expected ddt on stores
    } row_t;

    logic clk;
    logic arst_n;
    word_t idt;
    addr_t iad;
    addr_t dad;
    logic mreq;
    logic write;
    size_t size;
    wire [`XLEN-1:0] ddt;

    word_t rom [64];                        // instruction ROM, iad[7:2]
    logic [7:0] ram [256];                  // data RAM seen by the DUT
    logic [7:0] mem [256];                  // reference image for expectations
    word_t xr [32];                         // reference register values
    row_t rows [$];                         // one row per executed cycle
    addr_t pc;                              // reference pc while building
    logic built = 1'b0;
    logic [7:0] ra;
    word_t rdata;

    rv_core_top i_dut (
        .clk    (clk),
        .arst_n (arst_n),
        .idt    (idt),
        .iad    (iad),
        .dad    (dad),
        .mreq   (mreq),
        .write  (write),
        .size   (size),
        .ddt    (ddt)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;             // 100 ns period
    end

    assign idt = rom[iad[7:2]];             // zero-wait fetch
    assign ra  = dad[7:0];

    always_comb begin
        case (size)                         // right-justified, core extends
            `SIZE_B: rdata = {24'b0, ram[ra]};
            `SIZE_H: rdata = {16'b0, ram[ra + 8'd1], ram[ra]};
            default: rdata = {ram[ra + 8'd3], ram[ra + 8'd2], ram[ra + 8'd1], ram[ra]};
        endcase
    end
    assign ddt = (mreq && !write) ? rdata : 'z;

    always @(posedge clk) begin
        if (mreq && write) begin            // low size bytes of ddt
            ram[ra] <= ddt[7:0];
            if (size != `SIZE_B) ram[ra + 8'd1] <= ddt[15:8];
            if (size == `SIZE_W) begin
                ram[ra + 8'd2] <= ddt[23:16];
                ram[ra + 8'd3] <= ddt[31:24];
            end
        end
    end

    task automatic stop_run(string why);
        $display("%s", why);
        $display("Test failures found");
        $fatal(1, "run stopped");
    endtask

    task automatic check_addr(string name, addr_t got, addr_t exp);
        if (got !== exp)
            stop_run($sformatf("[FAIL] t=%0t %s got %h expected %h", $time, name, got, exp));
    endtask

    task automatic check_word(string name, word_t got, word_t exp);
        if (got !== exp)
            stop_run($sformatf("[FAIL] t=%0t %s got %h expected %h", $time, name, got, exp));
    endtask

    task automatic check_size(string name, size_t got, size_t exp);
        if (got !== exp)
            stop_run($sformatf("[FAIL] t=%0t %s got %0d expected %0d", $time, name, got, exp));
    endtask

    task automatic check_bit(string name, logic got, logic exp);
        if (got !== exp)
            stop_run($sformatf("[FAIL] t=%0t %s got %b expected %b", $time, name, got, exp));
    endtask

    function automatic word_t sext12(logic [11:0] imm);
        return {{20{imm[11]}}, imm};
    endfunction

    function automatic word_t enc_i(logic [11:0] imm, reg_idx_t rs1, logic [2:0] f3,
                                    reg_idx_t rd, logic [6:0] op);
        return {imm, rs1, f3, rd, op};
    endfunction

    function automatic word_t enc_s(logic [11:0] imm, reg_idx_t rs2, reg_idx_t rs1,
                                    logic [2:0] f3);
        return {imm[11:5], rs2, rs1, f3, imm[4:0], `OP_STORE};
    endfunction

    // ISA results for the arithmetic funct3 codes
    function automatic word_t alu_ref(logic [2:0] f3, logic sub, word_t a, word_t b);
        case (f3)
            3'b010:  return {31'b0, $signed(a) < $signed(b)};
            3'b100:  return a ^ b;
            3'b110:  return a | b;
            3'b111:  return a & b;
            default: return sub ? a - b : a + b;
        endcase
    endfunction

    task automatic add_row(word_t inst, logic req, logic wr, size_t sz, addr_t da, word_t wd);
        rows.push_back(row_t'{inst, pc, req, wr, sz, da, wd});
        pc = pc + 32'd4;
    endtask

    task automatic alu_i(logic [2:0] f3, reg_idx_t rd, reg_idx_t rs1, logic [11:0] imm);
        word_t v;
        v = alu_ref(f3, 1'b0, xr[rs1], sext12(imm));
        add_row(enc_i(imm, rs1, f3, rd, `OP_IMM), 1'b0, 1'b0, `SIZE_B, '0, '0);
        if (rd != 5'd0) xr[rd] = v;         // x0 stays zero
    endtask

    task automatic alu_r(logic sub, logic [2:0] f3, reg_idx_t rd, reg_idx_t rs1, reg_idx_t rs2);
        word_t v;
        v = alu_ref(f3, sub, xr[rs1], xr[rs2]);
        add_row({1'b0, sub, 5'b0, rs2, rs1, f3, rd, `OP_REG}, 1'b0, 1'b0, `SIZE_B, '0, '0);
        if (rd != 5'd0) xr[rd] = v;
    endtask

    task automatic load(logic [2:0] f3, reg_idx_t rd, reg_idx_t rs1, logic [11:0] off);
        addr_t a;
        word_t v;
        a = xr[rs1] + sext12(off);
        v = {mem[a[7:0] + 8'd3], mem[a[7:0] + 8'd2], mem[a[7:0] + 8'd1], mem[a[7:0]]};
        if (f3[1:0] == `SIZE_B) v = {{24{v[7]}}, v[7:0]};
        if (f3[1:0] == `SIZE_H) v = {{16{v[15]}}, v[15:0]};
        add_row(enc_i(off, rs1, f3, rd, `OP_LOAD), 1'b1, 1'b0, f3[1:0], a, '0);
        if (rd != 5'd0) xr[rd] = v;
    endtask

    task automatic store(logic [2:0] f3, reg_idx_t rs2, reg_idx_t rs1, logic [11:0] off);
        addr_t a;
        a = xr[rs1] + sext12(off);
        for (int k = 0; k < (1 << f3[1:0]); k++)
            mem[a[7:0] + 8'(k)] = xr[rs2][8*k +: 8];
        add_row(enc_s(off, rs2, rs1, f3), 1'b1, 1'b1, f3[1:0], a, xr[rs2]);
    endtask

    // offset +8, the slot in between holds a store that must not run
    task automatic branch(logic [2:0] f3, reg_idx_t rs1, reg_idx_t rs2);
        logic  taken;
        addr_t p;
        taken = (xr[rs1] == xr[rs2]) ^ f3[0];   // beq f3=0, bne f3=1
        p = pc;
        add_row({7'b0, rs2, rs1, f3, 5'b01000, `OP_BRANCH}, 1'b0, 1'b0, `SIZE_B, '0, '0);
        rom[pc[7:2]] = enc_s(12'h000, 5'd2, 5'd0, 3'b010);
        if (taken) pc = p + 32'd8;
    endtask

    task automatic upper(logic [6:0] op, reg_idx_t rd, logic [19:0] imm);
        word_t v;
        v = (op == `OP_AUIPC) ? {imm, 12'b0} + pc : {imm, 12'b0};
        add_row({imm, rd, op}, 1'b0, 1'b0, `SIZE_B, '0, '0);
        if (rd != 5'd0) xr[rd] = v;
    endtask

    task automatic jal(reg_idx_t rd);
        addr_t p;
        p = pc;
        add_row({20'h00800, rd, `OP_JAL}, 1'b0, 1'b0, `SIZE_B, '0, '0);  // jal rd, +8
        rom[pc[7:2]] = enc_s(12'h004, 5'd2, 5'd0, 3'b010);
        if (rd != 5'd0) xr[rd] = p + 32'd4;
        pc = p + 32'd8;
    endtask

    task automatic build_program();
        pc = `RESET_PC;
        for (int i = 0; i < 32; i++)
            xr[i] = '0;
        for (int i = 0; i < 64; i++)
            rom[i] = enc_i(12'(i), 5'd0, 3'b000, 5'd0, `OP_IMM);   // nop, tagged by slot
        for (int i = 0; i < 256; i++) begin
            ram[i] = 8'($urandom);
            mem[i] = ram[i];
        end
        ram[8'h41][7] = 1'b1;                   // negative items for lb and lh
        ram[8'h47][7] = 1'b1;
        mem[8'h41] = ram[8'h41];
        mem[8'h47] = ram[8'h47];
        alu_i(3'b000, 5'd1, 5'd0, 12'h080);     // base pointer 0x80
        alu_i(3'b000, 5'd2, 5'd0, 12'($urandom));
        alu_i(3'b000, 5'd3, 5'd0, 12'($urandom));
        alu_i(3'b010, 5'd4, 5'd2, 12'($urandom));  // slti
        alu_i(3'b100, 5'd5, 5'd2, 12'($urandom));  // xori
        alu_i(3'b110, 5'd6, 5'd3, 12'($urandom));  // ori
        alu_i(3'b111, 5'd7, 5'd3, 12'($urandom));  // andi
        alu_r(1'b0, 3'b000, 5'd8, 5'd2, 5'd3);
        alu_r(1'b1, 3'b000, 5'd9, 5'd2, 5'd3);     // sub
        alu_r(1'b0, 3'b010, 5'd10, 5'd2, 5'd3);
        alu_r(1'b0, 3'b100, 5'd11, 5'd5, 5'd6);
        alu_r(1'b0, 3'b110, 5'd12, 5'd5, 5'd7);
        alu_r(1'b0, 3'b111, 5'd13, 5'd6, 5'd7);
        for (int r = 2; r <= 13; r++)
            store(3'b010, 5'(r), 5'd1, 12'(4 * r - 8));   // 0x80..0xac
        load(3'b000, 5'd14, 5'd1, 12'hfc1);     // lb 0x41, random data
        load(3'b001, 5'd15, 5'd1, 12'hfc6);     // lh 0x46
        load(3'b010, 5'd16, 5'd1, 12'hfc8);     // lw 0x48
        store(3'b010, 5'd14, 5'd1, 12'h030);
        store(3'b010, 5'd15, 5'd1, 12'h034);
        store(3'b010, 5'd16, 5'd1, 12'h038);
        store(3'b000, 5'd3, 5'd1, 12'h041);     // sb 0xc1
        store(3'b001, 5'd2, 5'd1, 12'h046);     // sh 0xc6
        load(3'b000, 5'd17, 5'd1, 12'h041);
        load(3'b001, 5'd18, 5'd1, 12'h046);
        store(3'b010, 5'd17, 5'd1, 12'h03c);
        store(3'b010, 5'd18, 5'd1, 12'h048);
        branch(3'b000, 5'd1, 5'd0);             // beq falls through
        branch(3'b001, 5'd1, 5'd0);             // bne taken
        branch(3'b000, 5'd1, 5'd1);             // beq taken
        branch(3'b001, 5'd2, 5'd2);             // bne falls through
        upper(`OP_LUI, 5'd19, 20'($urandom));
        upper(`OP_AUIPC, 5'd20, 20'($urandom));
        jal(5'd21);
        store(3'b010, 5'd19, 5'd1, 12'h050);
        store(3'b010, 5'd20, 5'd1, 12'h054);
        store(3'b010, 5'd21, 5'd1, 12'h058);    // link value
        alu_i(3'b000, 5'd0, 5'd0, 12'h123);     // write to x0 dropped
        store(3'b010, 5'd0, 5'd1, 12'h05c);
        if (pc > 32'd256) stop_run("program does not fit in the instruction ROM");
        foreach (rows[r])
            rom[rows[r].iad[7:2]] = rows[r].inst;   // executed slots from the table
    endtask

    initial begin
        wait (built);
        #((rows.size() + 10 + 20) * 100);
        stop_run("watchdog expired before the program finished");
    end

    initial begin
        row_t exp;
        void'($urandom(27530));
        arst_n = 1'b0;
        build_program();
        built = 1'b1;
        repeat (10) begin                   // reset held 10 cycles
            @(negedge clk);
            check_addr("iad", iad, `RESET_PC);
            check_bit("mreq", mreq, 1'b0);
            check_bit("write", write, 1'b0);
        end
        @(posedge clk);
        arst_n <= 1'b1;
        foreach (rows[r]) begin             // mid-cycle sample, outputs settled
            @(negedge clk);
            exp = rows[r];
            check_addr("iad", iad, exp.iad);
            check_bit("mreq", mreq, exp.mreq);
            check_bit("write", write, exp.write);
            if (exp.mreq) begin
                check_size("size", size, exp.size);
                check_addr("dad", dad, exp.dad);
            end
            if (exp.write) check_word("ddt", ddt, exp.wdata);
        end
        $display("All tests passed!");
        $finish;
    end

endmodule
